// ==== source/osd_pkg.sv ====
package osd_pkg;

   // ####################
   // Word and flit types
   // ####################

   // One host word or one flit payload
   typedef logic [15:0] dii_word_t;

   // Endpoint address
   typedef logic [15:0] osd_id_t;

   typedef struct packed {
      dii_word_t data;
      logic      valid;
      logic      last;
   } dii_flit;

   // ####################
   // Packet type codes
   // ####################

   // Carried in flit 2 of every packet
   localparam dii_word_t OSD_REQ_READ   = 16'h0010;
   localparam dii_word_t OSD_REQ_WRITE  = 16'h0011;
   localparam dii_word_t OSD_RESP_READ  = 16'h0020;
   localparam dii_word_t OSD_RESP_WRITE = 16'h0021;
   localparam dii_word_t OSD_RESP_ERROR = 16'h0022;

   // ####################
   // Register file
   // ####################

   localparam dii_word_t OSD_VERSION  = 16'h0100;
   localparam int        OSD_NUM_REGS = 8;

endpackage

// ==== source/glip_channel.sv ====
`timescale 1ns/100ps

interface glip_channel;
   import osd_pkg::*;

   dii_word_t data;
   logic      valid;
   logic      ready;

   // Word moves when valid and ready are both high
   modport source (output data, output valid, input ready);

   modport sink (input data, input valid, output ready);

endinterface

// ==== source/dii_buffer.sv ====
`timescale 1ns/100ps

module dii_buffer #(
   parameter int SIZE = 8
) (
   input  logic                      clk,
   input  logic                      rst,
   input  osd_pkg::dii_flit          flit_in,
   output logic                      flit_in_ready,
   output osd_pkg::dii_flit          flit_out,
   input  logic                      flit_out_ready,
   output logic [$clog2(SIZE)-1:0]   packet_size
);
   import osd_pkg::*;

   localparam int PW = $clog2(SIZE);

   typedef logic [PW-1:0] ptr_t;
   typedef logic [PW:0]   fill_t;

   dii_word_t data_mem [SIZE];
   logic      last_mem [SIZE];
   // Length of each stored packet in arrival order
   ptr_t      len_mem  [SIZE];

   ptr_t  wr_ptr;
   ptr_t  rd_ptr;
   ptr_t  len_wr;
   ptr_t  len_rd;
   ptr_t  in_len;
   fill_t flit_count;
   fill_t pkt_count;
   logic  wr_en;
   logic  rd_en;
   logic  wr_last;
   logic  rd_last;

   function automatic ptr_t ptr_next(ptr_t p);
      return (p == ptr_t'(SIZE - 1)) ? '0 : p + 1'b1;
   endfunction

   assign flit_in_ready = (flit_count != fill_t'(SIZE));
   assign wr_en   = flit_in.valid & flit_in_ready;
   assign rd_en   = flit_out.valid & flit_out_ready;
   assign wr_last = wr_en & flit_in.last;
   assign rd_last = rd_en & flit_out.last;

   // Nothing leaves until a whole packet is stored
   assign flit_out.valid = (pkt_count != '0);
   assign flit_out.data  = data_mem[rd_ptr];
   assign flit_out.last  = last_mem[rd_ptr];
   assign packet_size    = len_mem[len_rd];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         data_mem[wr_ptr] <= flit_in.data;
         last_mem[wr_ptr] <= flit_in.last;
      end
      if (wr_last) begin
         len_mem[len_wr] <= in_len + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         len_wr     <= '0;
         len_rd     <= '0;
         in_len     <= '0;
         flit_count <= '0;
         pkt_count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= ptr_next(wr_ptr);
            in_len <= flit_in.last ? '0 : in_len + 1'b1;
         end
         if (wr_last) begin
            len_wr <= ptr_next(len_wr);
         end
         if (rd_en) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         if (rd_last) begin
            len_rd <= ptr_next(len_rd);
         end
         flit_count <= flit_count + fill_t'(wr_en) - fill_t'(rd_en);
         pkt_count  <= pkt_count + fill_t'(wr_last) - fill_t'(rd_last);
      end
   end

endmodule

// ==== source/osd_him.sv ====
`timescale 1ns/100ps

module osd_him #(
   parameter int BUF_SIZE = 8
) (
   input  logic              clk,
   input  logic              rst,
   glip_channel.sink         glip_in,
   glip_channel.source       glip_out,
   output osd_pkg::dii_flit  dii_out,
   input  logic              dii_out_ready,
   input  osd_pkg::dii_flit  dii_in,
   output logic              dii_in_ready
);
   import osd_pkg::*;

   localparam int SIZE_W = $clog2(BUF_SIZE);

   // ####################
   // Ingress
   // ####################

   logic              ingress_active;
   logic [SIZE_W-1:0] ingress_size;
   dii_word_t         ingress_be;

   assign ingress_be = {glip_in.data[7:0], glip_in.data[15:8]};

   // Size word is swallowed and later words pass straight through
   assign glip_in.ready = !ingress_active | dii_out_ready;
   assign dii_out.data  = ingress_be;
   assign dii_out.valid = ingress_active & glip_in.valid;
   assign dii_out.last  = ingress_active & (ingress_size == '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         ingress_active <= 1'b0;
      end else if (glip_in.valid & glip_in.ready) begin
         if (!ingress_active) begin
            ingress_size   <= ingress_be[SIZE_W-1:0] - 1'b1;
            ingress_active <= 1'b1;
         end else begin
            ingress_size <= ingress_size - 1'b1;
            if (ingress_size == '0) begin
               ingress_active <= 1'b0;
            end
         end
      end
   end

   // ####################
   // Egress
   // ####################

   dii_flit           dii_egress;
   logic              dii_egress_ready;
   logic [SIZE_W-1:0] egress_packet_size;
   logic              egress_active;
   dii_word_t         egress_be;

   // Idle means the size word is on the channel
   always_comb begin
      egress_be = '0;
      if (!egress_active) begin
         egress_be[SIZE_W-1:0] = egress_packet_size;
      end else begin
         egress_be = dii_egress.data;
      end
   end

   assign glip_out.data    = {egress_be[7:0], egress_be[15:8]};
   assign glip_out.valid   = dii_egress.valid;
   assign dii_egress_ready = egress_active & glip_out.ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         egress_active <= 1'b0;
      end else if (!egress_active) begin
         if (dii_egress.valid & glip_out.ready) begin
            egress_active <= 1'b1;
         end
      end else if (dii_egress_ready & dii_egress.last) begin
         egress_active <= 1'b0;
      end
   end

   dii_buffer #(.SIZE(BUF_SIZE)) i_egress_buffer (
      .clk            (clk),
      .rst            (rst),
      .flit_in        (dii_in),
      .flit_in_ready  (dii_in_ready),
      .flit_out       (dii_egress),
      .flit_out_ready (dii_egress_ready),
      .packet_size    (egress_packet_size)
   );

endmodule

// ==== source/osd_reg_endpoint.sv ====
`timescale 1ns/100ps

module osd_reg_endpoint #(
   parameter osd_pkg::osd_id_t ENDPOINT_ID = 16'd1
) (
   input  logic             clk,
   input  logic             rst,
   input  osd_pkg::dii_flit flit_in,
   output logic             flit_in_ready,
   output osd_pkg::dii_flit flit_out,
   input  logic             flit_out_ready
);
   import osd_pkg::*;

   localparam int AW = $clog2(OSD_NUM_REGS);

   typedef enum logic [1:0] {
      IDLE,
      RECEIVE,
      DROP,
      RESPOND
   } state_t;

   state_t state;

   // Flit position within the request and the response
   logic [2:0] in_idx;
   logic [1:0] out_idx;

   osd_id_t   req_src;
   dii_word_t req_type;
   dii_word_t req_addr;
   dii_word_t req_data;

   // Register 0 is the fixed version word
   dii_word_t regs [1:OSD_NUM_REGS-1];

   logic [AW-1:0] reg_idx;
   logic          addr_ok;
   dii_word_t     resp_type;
   dii_word_t     rd_data;
   logic [1:0]    resp_last;
   logic          in_xfer;
   logic          out_xfer;

   assign flit_in_ready = (state != RESPOND);
   assign in_xfer  = flit_in.valid & flit_in_ready;
   assign out_xfer = flit_out.valid & flit_out_ready;

   assign reg_idx = req_addr[AW-1:0];
   assign addr_ok = (req_addr < 16'(OSD_NUM_REGS));

   // ####################
   // Request capture
   // ####################

   always_ff @(posedge clk) begin
      if ((state == RECEIVE) && in_xfer) begin
         case (in_idx)
            3'd1: req_src  <= flit_in.data;
            3'd2: req_type <= flit_in.data;
            3'd3: req_addr <= flit_in.data;
            3'd4: req_data <= flit_in.data;
            default: ;
         endcase
      end
   end

   // ####################
   // Response build
   // ####################

   always_comb begin
      if (addr_ok && (req_type == OSD_REQ_READ)) begin
         resp_type = OSD_RESP_READ;
         resp_last = 2'd3;
      end else if (addr_ok && (req_type == OSD_REQ_WRITE)) begin
         resp_type = OSD_RESP_WRITE;
         resp_last = 2'd2;
      end else begin
         resp_type = OSD_RESP_ERROR;
         resp_last = 2'd2;
      end
   end

   always_comb begin
      if (reg_idx == '0) begin
         rd_data = OSD_VERSION;
      end else begin
         rd_data = regs[reg_idx];
      end
   end

   always_comb begin
      case (out_idx)
         2'd0:    flit_out.data = req_src;
         2'd1:    flit_out.data = ENDPOINT_ID;
         2'd2:    flit_out.data = resp_type;
         default: flit_out.data = rd_data;
      endcase
   end

   assign flit_out.valid = (state == RESPOND);
   assign flit_out.last  = (out_idx == resp_last);

   // ####################
   // Control FSM
   // ####################

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= IDLE;
         in_idx  <= '0;
         out_idx <= '0;
         for (int i = 1; i < OSD_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         case (state)
            IDLE: begin
               if (in_xfer) begin
                  in_idx <= 3'd1;
                  if (!flit_in.last) begin
                     state <= (flit_in.data == ENDPOINT_ID) ? RECEIVE : DROP;
                  end
               end
            end
            RECEIVE: begin
               if (in_xfer) begin
                  if (in_idx != 3'd7) begin
                     in_idx <= in_idx + 1'b1;
                  end
                  if (flit_in.last) begin
                     state   <= RESPOND;
                     out_idx <= '0;
                  end
               end
            end
            DROP: begin
               if (in_xfer && flit_in.last) begin
                  state <= IDLE;
               end
            end
            RESPOND: begin
               if (out_xfer) begin
                  out_idx <= out_idx + 1'b1;
                  if (flit_out.last) begin
                     state <= IDLE;
                     // Commit the write once the ack has gone out
                     if ((resp_type == OSD_RESP_WRITE) && (reg_idx != '0)) begin
                        regs[reg_idx] <= req_data;
                     end
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

// ==== source/osd_host_subsys.sv ====
`timescale 1ns/100ps

module osd_host_subsys #(
   parameter int               BUF_SIZE    = 8,
   parameter osd_pkg::osd_id_t ENDPOINT_ID = 16'd1
) (
   input  logic                clk,
   input  logic                rst,

   input  osd_pkg::dii_word_t  glip_in_data,
   input  logic                glip_in_valid,
   output logic                glip_in_ready,

   output osd_pkg::dii_word_t  glip_out_data,
   output logic                glip_out_valid,
   input  logic                glip_out_ready
);
   import osd_pkg::*;

   // ####################
   // Host channels
   // ####################

   glip_channel glip_in_if ();
   glip_channel glip_out_if ();

   assign glip_in_if.data  = glip_in_data;
   assign glip_in_if.valid = glip_in_valid;
   assign glip_in_ready    = glip_in_if.ready;

   assign glip_out_data     = glip_out_if.data;
   assign glip_out_valid    = glip_out_if.valid;
   assign glip_out_if.ready = glip_out_ready;

   // ####################
   // Debug network
   // ####################

   // Requests toward the endpoint and responses back
   dii_flit dii_req;
   logic    dii_req_ready;
   dii_flit dii_resp;
   logic    dii_resp_ready;

   osd_him #(.BUF_SIZE(BUF_SIZE)) i_osd_him (
      .clk           (clk),
      .rst           (rst),
      .glip_in       (glip_in_if.sink),
      .glip_out      (glip_out_if.source),
      .dii_out       (dii_req),
      .dii_out_ready (dii_req_ready),
      .dii_in        (dii_resp),
      .dii_in_ready  (dii_resp_ready)
   );

   osd_reg_endpoint #(.ENDPOINT_ID(ENDPOINT_ID)) i_osd_reg_endpoint (
      .clk            (clk),
      .rst            (rst),
      .flit_in        (dii_req),
      .flit_in_ready  (dii_req_ready),
      .flit_out       (dii_resp),
      .flit_out_ready (dii_resp_ready)
   );

endmodule

// ==== bench/osd_checker.sv ====
`timescale 1ns/100ps

module osd_checker #(
   parameter osd_pkg::osd_id_t ENDPOINT_ID = 16'd1
) (
   input  logic               clk,
   input  logic               rst,
   input  osd_pkg::dii_word_t glip_in_data,
   input  logic               glip_in_valid,
   input  logic               glip_in_ready,
   input  osd_pkg::dii_word_t glip_out_data,
   input  logic               glip_out_valid,
   input  logic               glip_out_ready,
   input  osd_pkg::dii_word_t expect_type,
   output int                 tests_done,
   output int                 check_count,
   output int                 error_count
);
   import osd_pkg::*;

   dii_word_t model [OSD_NUM_REGS];
   dii_word_t req [$];
   dii_word_t expected [$];
   int        req_len;
   logic      in_packet;
   int        test_errors;

   function automatic dii_word_t swap_bytes(dii_word_t w);
      return {w[7:0], w[15:8]};
   endfunction

   task automatic finish_test(input string note);
      $display("Test %0d: %s, %s", tests_done, note, (test_errors == 0) ? "ok" : "failed");
      tests_done++;
      test_errors = 0;
   endtask

   // ####################
   // Response prediction
   // ####################

   task automatic predict_response();
      dii_word_t resp_type;
      logic      in_range;
      int        idx;
      in_range = (req[3] < 16'(OSD_NUM_REGS));
      idx = int'(req[3][2:0]);
      if (req[0] != ENDPOINT_ID) begin
         resp_type = '0;
      end else if (in_range && (req[2] == OSD_REQ_READ)) begin
         resp_type = OSD_RESP_READ;
      end else if (in_range && (req[2] == OSD_REQ_WRITE)) begin
         resp_type = OSD_RESP_WRITE;
      end else begin
         resp_type = OSD_RESP_ERROR;
      end
      check_count++;
      if (resp_type != expect_type) begin
         $display("CHECK FAILED at %0d ns: predicted response type expected %h got %h",
                  $time, expect_type, resp_type);
         error_count++;
         test_errors++;
      end
      if (resp_type == '0) begin
         finish_test("dropped, no response");
      end else begin
         expected.push_back((resp_type == OSD_RESP_READ) ? 16'd4 : 16'd3);
         expected.push_back(req[1]);
         expected.push_back(ENDPOINT_ID);
         expected.push_back(resp_type);
         if (resp_type == OSD_RESP_READ) begin
            expected.push_back(model[idx]);
         end
         // Register 0 ignores writes
         if ((resp_type == OSD_RESP_WRITE) && (idx != 0)) begin
            model[idx] = req[4];
         end
      end
   endtask

   always @(posedge clk) begin
      if (rst) begin
         model[0] = OSD_VERSION;
         for (int i = 1; i < OSD_NUM_REGS; i++) begin
            model[i] = '0;
         end
         req.delete();
         expected.delete();
         in_packet = 1'b0;
         tests_done = 0;
         check_count = 0;
         error_count = 0;
         test_errors = 0;
      end else begin
         if (glip_out_valid && glip_out_ready) begin
            if (expected.size() == 0) begin
               $display("Unexpected response word %h at %0d ns with no response pending",
                        glip_out_data, $time);
               error_count++;
            end else begin
               check_count++;
               if (swap_bytes(glip_out_data) != expected[0]) begin
                  $display("CHECK FAILED at %0d ns: glip_out_data expected %h got %h",
                           $time, swap_bytes(expected[0]), glip_out_data);
                  error_count++;
                  test_errors++;
               end
               void'(expected.pop_front());
               if (expected.size() == 0) begin
                  finish_test("response complete");
               end
            end
         end
         // Reassemble host requests
         if (glip_in_valid && glip_in_ready) begin
            if (!in_packet) begin
               req_len = int'(swap_bytes(glip_in_data));
               req.delete();
               in_packet = 1'b1;
            end else begin
               req.push_back(swap_bytes(glip_in_data));
               if (req.size() == req_len) begin
                  in_packet = 1'b0;
                  predict_response();
               end
            end
         end
      end
   end

endmodule

// ==== bench/tb_osd_host_subsys.sv ====
`timescale 1ns/100ps

module tb_osd_host_subsys;
   import osd_pkg::*;

   localparam int      BUF_SIZE        = 8;
   localparam osd_id_t ENDPOINT_ID     = 16'd1;
   localparam int      CYCLES_PER_TEST = 60;

   typedef struct packed {
      osd_id_t   dest;
      dii_word_t rtype;
      dii_word_t addr;
      dii_word_t data;
      logic      stall;
      dii_word_t resp;
   } test_t;

   test_t       tests [$];
   logic        clk = 1'b0;
   logic        rst;
   dii_word_t   glip_in_data;
   logic        glip_in_valid;
   logic        glip_in_ready;
   dii_word_t   glip_out_data;
   logic        glip_out_valid;
   logic        glip_out_ready;
   dii_word_t   expect_type;
   logic        stall_en;
   logic [31:0] lfsr;
   int          tests_done;
   int          check_count;
   int          error_count;
   int          cycle_count;
   int          timeout_limit;

   osd_host_subsys #(.BUF_SIZE(BUF_SIZE), .ENDPOINT_ID(ENDPOINT_ID)) i_osd_host_subsys (
      .clk            (clk),
      .rst            (rst),
      .glip_in_data   (glip_in_data),
      .glip_in_valid  (glip_in_valid),
      .glip_in_ready  (glip_in_ready),
      .glip_out_data  (glip_out_data),
      .glip_out_valid (glip_out_valid),
      .glip_out_ready (glip_out_ready)
   );

   osd_checker #(.ENDPOINT_ID(ENDPOINT_ID)) i_osd_checker (
      .clk            (clk),
      .rst            (rst),
      .glip_in_data   (glip_in_data),
      .glip_in_valid  (glip_in_valid),
      .glip_in_ready  (glip_in_ready),
      .glip_out_data  (glip_out_data),
      .glip_out_valid (glip_out_valid),
      .glip_out_ready (glip_out_ready),
      .expect_type    (expect_type),
      .tests_done     (tests_done),
      .check_count    (check_count),
      .error_count    (error_count)
   );

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output dii_word_t v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[14:0], lfsr[0]};
      end
   endtask

   task automatic add_test(input osd_id_t dest, input dii_word_t rtype, input dii_word_t addr,
                           input logic rand_data, input logic stall, input dii_word_t resp);
      test_t t;
      t.dest  = dest;
      t.rtype = rtype;
      t.addr  = addr;
      t.stall = stall;
      t.resp  = resp;
      t.data  = 16'h5a00 | addr;
      if (rand_data) begin
         take_bits(16, t.data);
      end
      tests.push_back(t);
   endtask

   // Words go out big-endian and are held until accepted
   task automatic send_word(input dii_word_t w);
      glip_in_data  <= {w[7:0], w[15:8]};
      glip_in_valid <= 1'b1;
      @(negedge clk);
      while (!glip_in_ready) begin
         @(negedge clk);
      end
      @(posedge clk);
      glip_in_valid <= 1'b0;
   endtask

   task automatic send_packet(input test_t t, input int idx);
      send_word((t.rtype == OSD_REQ_WRITE) ? 16'd5 : 16'd4);
      send_word(t.dest);
      send_word(16'h0040 + 16'(idx));
      send_word(t.rtype);
      send_word(t.addr);
      if (t.rtype == OSD_REQ_WRITE) begin
         send_word(t.data);
      end
   endtask

   always #5 clk = ~clk;

   // Random output stalls
   always @(posedge clk) begin
      if (stall_en) begin
         lfsr = lfsr_step(lfsr);
         glip_out_ready <= lfsr[0];
      end else begin
         glip_out_ready <= 1'b1;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_limit) begin
         $display("Timeout after %0d cycles, test %0d got no complete response",
                  cycle_count, tests_done);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   initial begin
      rst            = 1'b1;
      glip_in_data   = '0;
      glip_in_valid  = 1'b0;
      glip_out_ready = 1'b1;
      stall_en       = 1'b0;
      expect_type    = '0;
      lfsr           = 32'he1b3;
      cycle_count    = 0;
      add_test(ENDPOINT_ID, OSD_REQ_WRITE, 16'd1, 1'b0, 1'b0, OSD_RESP_WRITE);
      add_test(ENDPOINT_ID, OSD_REQ_READ, 16'd1, 1'b0, 1'b0, OSD_RESP_READ);
      add_test(ENDPOINT_ID, OSD_REQ_WRITE, 16'd5, 1'b1, 1'b0, OSD_RESP_WRITE);
      add_test(ENDPOINT_ID, OSD_REQ_READ, 16'd5, 1'b0, 1'b0, OSD_RESP_READ);
      add_test(ENDPOINT_ID, OSD_REQ_READ, 16'd0, 1'b0, 1'b0, OSD_RESP_READ);
      add_test(ENDPOINT_ID, OSD_REQ_WRITE, 16'd0, 1'b1, 1'b0, OSD_RESP_WRITE);
      add_test(ENDPOINT_ID, OSD_REQ_READ, 16'd0, 1'b0, 1'b0, OSD_RESP_READ);
      add_test(ENDPOINT_ID, OSD_REQ_READ, 16'd8, 1'b0, 1'b0, OSD_RESP_ERROR);
      add_test(ENDPOINT_ID, OSD_REQ_WRITE, 16'h0020, 1'b1, 1'b0, OSD_RESP_ERROR);
      add_test(ENDPOINT_ID, 16'h0033, 16'd2, 1'b0, 1'b0, OSD_RESP_ERROR);
      add_test(16'd2, OSD_REQ_WRITE, 16'd3, 1'b1, 1'b0, 16'h0000);
      add_test(ENDPOINT_ID, OSD_REQ_READ, 16'd3, 1'b0, 1'b0, OSD_RESP_READ);
      add_test(ENDPOINT_ID, OSD_REQ_WRITE, 16'd7, 1'b1, 1'b1, OSD_RESP_WRITE);
      add_test(ENDPOINT_ID, OSD_REQ_READ, 16'd7, 1'b0, 1'b1, OSD_RESP_READ);
      add_test(ENDPOINT_ID, OSD_REQ_WRITE, 16'd2, 1'b1, 1'b1, OSD_RESP_WRITE);
      add_test(ENDPOINT_ID, OSD_REQ_READ, 16'd2, 1'b0, 1'b1, OSD_RESP_READ);
      timeout_limit = tests.size() * CYCLES_PER_TEST + 10;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < tests.size(); i++) begin
         expect_type <= tests[i].resp;
         stall_en    <= tests[i].stall;
         send_packet(tests[i], i);
         @(negedge clk);
         while (tests_done < i + 1) begin
            @(negedge clk);
         end
         @(posedge clk);
      end
      $display("Tests run: %0d of %0d, checks: %0d, errors: %0d",
               tests_done, tests.size(), check_count, error_count);
      if ((error_count == 0) && (tests_done == tests.size())) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
source/osd_pkg.sv
source/glip_channel.sv
source/dii_buffer.sv
source/osd_him.sv
source/osd_reg_endpoint.sv
source/osd_host_subsys.sv
bench/osd_checker.sv
bench/tb_osd_host_subsys.sv

// ==== Makefile ====
TOP = tb_osd_host_subsys

.PHONY: all lint clean

all:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -o sim
	out="$$(./obj_dir/sim)"; echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TOP)
	verilator --lint-only -Wall -f verilog.f --top-module osd_host_subsys

clean:
	rm -rf obj_dir
